// File: src/avionics_cfg.svh
// Flight-control core configuration
// Timing scale, pulse limits and arming constants, shrunk for simulation
`ifndef AVIONICS_CFG_SVH
`define AVIONICS_CFG_SVH

// clk cycles per microsecond tick
`define US_DIV       4
// Microsecond ticks per millisecond tick
`define MS_DIV       50

// Legal radio pulse range, in us ticks
`define PULSE_MIN    100
`define PULSE_MAX    200
// Slack accepted outside the legal range before a pulse is thrown away
`define PULSE_GUARD  20

// ESC frame period, in us ticks
`define FRAME_TICKS  400

// Arm stick channel and its threshold
`define ARM_CH       4
`define ARM_THRESH   170
// Consecutive ms ticks above threshold before arming
`define ARM_HOLD     3

// Radio and ESC channel count
`define N_CH         8

`endif

// File: src/avionics_pkg.sv
// Flight-control core types
// Board state, pulse widths, channel bundle, tick strobes and timestamp
`default_nettype none

`include "avionics_cfg.svh"

package avionics_pkg;

  // Board life cycle, same encoding as the avionics top level
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    STARTUP  = 2'd1,
    RUNNING  = 2'd2,
    SHUTDOWN = 2'd3
  } board_state_e;

  // Pulse width in us ticks
  typedef logic [8:0] width_t;

  // One captured channel
  typedef struct packed {
    width_t width;
    logic   valid;
  } pulse_width_t;

  // All radio channels, channel 0 in the low bits
  typedef pulse_width_t [`N_CH-1:0] chan_vals_t;

  // Tick strobes, ms always lands on a us tick
  typedef struct packed {
    logic us;
    logic ms;
  } tick_t;

  // Milliseconds since entering RUNNING
  typedef logic [23:0] timestamp_t;

endpackage

`default_nettype wire

// File: src/tick_gen.sv
// Tick generator
// Prescales clk into us and ms strobes, held at zero while the board idles
`timescale 1ns/1ps
`default_nettype none

`include "avionics_cfg.svh"

module tick_gen import avionics_pkg::*; (
  input  wire          clk,
  input  wire          arst_n,
  input  wire board_state_e board_state,
  output tick_t        ticks
);

  localparam int US_W = $clog2(`US_DIV);
  localparam int MS_W = $clog2(`MS_DIV);

  logic [US_W-1:0] us_cnt;
  logic [MS_W-1:0] ms_cnt;
  logic            us_wrap;
  logic            ms_wrap;

  // Last clock of a us period, last us tick of a ms period
  assign us_wrap = (us_cnt == US_W'(`US_DIV - 1));
  assign ms_wrap = (ms_cnt == MS_W'(`MS_DIV - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      us_cnt <= '0;
      ms_cnt <= '0;
      ticks  <= '0;
    end else if (board_state == IDLE) begin
      // Restart both prescalers from zero
      us_cnt <= '0;
      ms_cnt <= '0;
      ticks  <= '0;
    end else begin
      ticks.us <= us_wrap;
      ticks.ms <= us_wrap && ms_wrap;
      if (us_wrap) begin
        us_cnt <= '0;
        // ms prescaler advances once per us tick
        ms_cnt <= ms_wrap ? '0 : ms_cnt + 1'b1;
      end else begin
        us_cnt <= us_cnt + 1'b1;
      end
    end
  end

  // Downstream blocks count us ticks and sample ms on the same edge
  a_ms_on_us: assert property (@(posedge clk) disable iff (!arst_n)
    ticks.ms |-> ticks.us);

endmodule

`default_nettype wire

// File: src/pulse_capture.sv
// Radio pulse capture
// Times each channel's high pulse in us ticks, rejects widths outside the
// guard band and clamps the rest into the legal range
`timescale 1ns/1ps
`default_nettype none

`include "avionics_cfg.svh"

module pulse_capture import avionics_pkg::*; (
  input  wire               clk,
  input  wire               arst_n,
  input  wire board_state_e board_state,
  input  wire tick_t        ticks,
  input  wire [`N_CH-1:0]   radio_sig,
  output chan_vals_t        radio_vals
);

  localparam width_t LO_GUARD = width_t'(`PULSE_MIN - `PULSE_GUARD);
  localparam width_t HI_GUARD = width_t'(`PULSE_MAX + `PULSE_GUARD);

  logic [`N_CH-1:0] sig_s1;
  logic [`N_CH-1:0] sig_s2;
  logic [`N_CH-1:0] sig_s3;
  logic [`N_CH-1:0] fall;
  logic [`N_CH-1:0] meas_stb;
  logic [`N_CH-1:0] chk_stb;
  logic [`N_CH-1:0] chk_ok;
  width_t           cnt    [`N_CH];
  width_t           meas_w [`N_CH];
  width_t           chk_w  [`N_CH];

  // Pull a width into PULSE_MIN..PULSE_MAX
  function automatic width_t clamp_w(input width_t w);
    width_t r;
    r = w;
    if (w < width_t'(`PULSE_MIN)) r = width_t'(`PULSE_MIN);
    if (w > width_t'(`PULSE_MAX)) r = width_t'(`PULSE_MAX);
    return r;
  endfunction

  // Falling edge after the two-flop synchronizer
  assign fall = sig_s3 & ~sig_s2;

  // Width pipeline, no reset needed, qualified by the strobes below
  always_ff @(posedge clk) begin
    for (int i = 0; i < `N_CH; i++) begin
      if (fall[i]) meas_w[i] <= cnt[i];
      chk_ok[i] <= (meas_w[i] >= LO_GUARD) && (meas_w[i] <= HI_GUARD);
      chk_w[i]  <= clamp_w(meas_w[i]);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n || board_state == IDLE) begin
      sig_s1     <= '0;
      sig_s2     <= '0;
      sig_s3     <= '0;
      meas_stb   <= '0;
      chk_stb    <= '0;
      radio_vals <= '0;
      for (int i = 0; i < `N_CH; i++) cnt[i] <= '0;
    end else begin
      sig_s1   <= radio_sig;
      sig_s2   <= sig_s1;
      sig_s3   <= sig_s2;
      // Stage 1 catches the count, stage 2 checks it, stage 3 stores
      meas_stb <= fall;
      chk_stb  <= meas_stb;
      for (int i = 0; i < `N_CH; i++) begin
        if (fall[i]) begin
          cnt[i] <= '0;
        end else if (sig_s2[i] && ticks.us && cnt[i] != '1) begin
          // Saturates on a stuck-high input
          cnt[i] <= cnt[i] + 1'b1;
        end
        // Rejected pulses keep the previous value
        if (chk_stb[i] && chk_ok[i]) begin
          radio_vals[i].width <= chk_w[i];
          radio_vals[i].valid <= 1'b1;
        end
      end
    end
  end

  // Consumers rely on valid widths being inside the legal range
  for (genvar g = 0; g < `N_CH; g++) begin : g_range
    a_width_legal: assert property (@(posedge clk) disable iff (!arst_n)
      radio_vals[g].valid |->
        (radio_vals[g].width >= width_t'(`PULSE_MIN)) &&
        (radio_vals[g].width <= width_t'(`PULSE_MAX)));
  end

endmodule

`default_nettype wire

// File: src/arm_switch.sv
// Arm switch detector
// Raises the motor flag once the arm stick has stayed high for a few ms
`timescale 1ns/1ps
`default_nettype none

`include "avionics_cfg.svh"

module arm_switch import avionics_pkg::*; (
  input  wire               clk,
  input  wire               arst_n,
  input  wire board_state_e board_state,
  input  wire tick_t        ticks,
  input  wire chan_vals_t   radio_vals,
  output logic              motor_flag
);

  localparam int HOLD_W = $clog2(`ARM_HOLD + 1);

  logic [HOLD_W-1:0] hold_cnt;
  logic              stick_hi;

  // Arm stick must be a real capture and past the threshold
  assign stick_hi = radio_vals[`ARM_CH].valid &&
                    (radio_vals[`ARM_CH].width > width_t'(`ARM_THRESH));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hold_cnt   <= '0;
      motor_flag <= 1'b0;
    end else if (board_state == IDLE) begin
      hold_cnt   <= '0;
      motor_flag <= 1'b0;
    end else if (ticks.ms) begin
      if (!stick_hi) begin
        // One low sample drops the flag and restarts qualification
        hold_cnt   <= '0;
        motor_flag <= 1'b0;
      end else if (hold_cnt == HOLD_W'(`ARM_HOLD - 1)) begin
        // ARM_HOLD-th high sample, counter parks here
        motor_flag <= 1'b1;
      end else begin
        hold_cnt <= hold_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/esc_pwm.sv
// ESC pulse generator
// Frames all eight motor outputs, each high for its latched width at frame
// start, and forces every output low while the motors are disabled
`timescale 1ns/1ps
`default_nettype none

`include "avionics_cfg.svh"

module esc_pwm import avionics_pkg::*; (
  input  wire               clk,
  input  wire               arst_n,
  input  wire board_state_e board_state,
  input  wire tick_t        ticks,
  input  wire               motor_en,
  input  wire chan_vals_t   radio_vals,
  output logic [`N_CH-1:0]  esc_sig
);

  localparam int FRAME_W = $clog2(`FRAME_TICKS);

  logic               active;
  logic               running;
  logic               frame_start;
  logic [FRAME_W-1:0] frame_cnt;
  logic [FRAME_W-1:0] frame_nxt;
  width_t             lat_w [`N_CH];

  assign active    = motor_en && (board_state != IDLE);
  // First us tick after enable, then every FRAME_TICKS ticks
  assign frame_start = ticks.us &&
                       (!running || frame_cnt == FRAME_W'(`FRAME_TICKS - 1));
  assign frame_nxt = frame_cnt + 1'b1;

  // Widths are frozen for the whole frame
  always_ff @(posedge clk) begin
    if (active && frame_start) begin
      for (int i = 0; i < `N_CH; i++) begin
        // Lost channel falls back to minimum throttle
        lat_w[i] <= radio_vals[i].valid ? radio_vals[i].width : width_t'(`PULSE_MIN);
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      running   <= 1'b0;
      frame_cnt <= '0;
      esc_sig   <= '0;
    end else if (!active) begin
      running   <= 1'b0;
      frame_cnt <= '0;
      esc_sig   <= '0;
    end else if (frame_start) begin
      running   <= 1'b1;
      frame_cnt <= '0;
      // Every width is at least PULSE_MIN, so all outputs start high
      esc_sig   <= '1;
    end else if (ticks.us) begin
      frame_cnt <= frame_nxt;
      for (int i = 0; i < `N_CH; i++) begin
        // High for ticks 0..width-1 of the frame
        esc_sig[i] <= (width_t'(frame_nxt) < lat_w[i]);
      end
    end
  end

  // Disabled motors see no pulse after one clock
  a_off_when_disabled: assert property (@(posedge clk) disable iff (!arst_n)
    !motor_en |=> (esc_sig == '0));

endmodule

`default_nettype wire

// File: src/board_ctrl.sv
// Board controller
// Idle, startup, running and shutdown sequencing, motor enable toggle
// from the arm flag, and the running millisecond timestamp
`timescale 1ns/1ps
`default_nettype none

module board_ctrl import avionics_pkg::*; (
  input  wire          clk,
  input  wire          arst_n,
  input  wire          shutdown_btn,
  input  wire tick_t   ticks,
  input  wire          motor_flag,
  output board_state_e board_state,
  output logic         motor_en,
  output timestamp_t   timestamp
);

  board_state_e state_d;
  logic [1:0]   btn_sync;
  logic         btn_prev;
  logic         btn_rise;
  logic         flag_prev;
  logic         flag_rise;

  // Button edge after two-flop synchronizer
  assign btn_rise  = btn_sync[1] & ~btn_prev;
  // Arm flag is already synchronous
  assign flag_rise = motor_flag & ~flag_prev;

  always_comb begin
    state_d = board_state;
    case (board_state)
      // Straight through to startup
      IDLE:     state_d = STARTUP;
      // No startup work in this core
      STARTUP:  state_d = RUNNING;
      RUNNING: begin
        if (btn_rise) state_d = SHUTDOWN;
      end
      // Back through idle clears the datapath
      SHUTDOWN: state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      board_state <= IDLE;
      btn_sync    <= '0;
      btn_prev    <= 1'b0;
      flag_prev   <= 1'b0;
      motor_en    <= 1'b0;
      timestamp   <= '0;
    end else begin
      board_state <= state_d;
      btn_sync    <= {btn_sync[0], shutdown_btn};
      btn_prev    <= btn_sync[1];
      flag_prev   <= motor_flag;

      // Motors only spin while running, toggled on each arm edge
      if (state_d != RUNNING) begin
        motor_en <= 1'b0;
      end else if (flag_rise) begin
        motor_en <= ~motor_en;
      end

      // ms count restarts on every entry to RUNNING
      if (state_d != RUNNING) begin
        timestamp <= '0;
      end else if (ticks.ms) begin
        timestamp <= timestamp + 1'b1;
      end
    end
  end

  // Enable is dropped on the same edge that leaves RUNNING
  a_motor_running: assert property (@(posedge clk) disable iff (!arst_n)
    motor_en |-> (board_state == RUNNING));

endmodule

`default_nettype wire

// File: src/avionics_top.sv
// Flight-control core top level
// Board controller plus tick, radio capture, arming and ESC datapath
`timescale 1ns/1ps
`default_nettype none

`include "avionics_cfg.svh"

module avionics_top import avionics_pkg::*; (
  input  wire              clk,
  input  wire              arst_n,
  input  wire              shutdown_btn,
  input  wire [`N_CH-1:0]  radio_sig,
  output logic [`N_CH-1:0] esc_sig,
  output board_state_e     board_state,
  output logic             motor_en,
  output timestamp_t       timestamp,
  output chan_vals_t       radio_vals
);

  tick_t ticks;
  logic  motor_flag;

  // us and ms strobes
  tick_gen u_tick_gen (
    .clk         (clk),
    .arst_n      (arst_n),
    .board_state (board_state),
    .ticks       (ticks)
  );

  // Radio receiver inputs
  pulse_capture u_pulse_capture (
    .clk         (clk),
    .arst_n      (arst_n),
    .board_state (board_state),
    .ticks       (ticks),
    .radio_sig   (radio_sig),
    .radio_vals  (radio_vals)
  );

  // Arm stick qualification
  arm_switch u_arm_switch (
    .clk         (clk),
    .arst_n      (arst_n),
    .board_state (board_state),
    .ticks       (ticks),
    .radio_vals  (radio_vals),
    .motor_flag  (motor_flag)
  );

  // Radio values go straight to the motors
  esc_pwm u_esc_pwm (
    .clk         (clk),
    .arst_n      (arst_n),
    .board_state (board_state),
    .ticks       (ticks),
    .motor_en    (motor_en),
    .radio_vals  (radio_vals),
    .esc_sig     (esc_sig)
  );

  board_ctrl u_board_ctrl (
    .clk          (clk),
    .arst_n       (arst_n),
    .shutdown_btn (shutdown_btn),
    .ticks        (ticks),
    .motor_flag   (motor_flag),
    .board_state  (board_state),
    .motor_en     (motor_en),
    .timestamp    (timestamp)
  );

endmodule

`default_nettype wire

// File: tests/tb_avionics.sv
// Flight-control core testbench
// Random radio pulses, arming, ESC framing and shutdown against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "avionics_cfg.svh"

module tb_avionics import avionics_pkg::*; ();

  localparam int MS_CLKS     = `US_DIV * `MS_DIV;
  localparam int FRAME_CLKS  = `FRAME_TICKS * `US_DIV;
  // Worst-case length of tests 2 to 6 in ESC frames, test 1 is a few clocks
  localparam int TEST_FRAMES = 2 + 2 + 3 + 4 + 2;
  localparam int CYCLE_LIMIT = TEST_FRAMES * FRAME_CLKS + 2000;

  logic             clk;
  logic             arst_n;
  logic             shutdown_btn;
  logic [`N_CH-1:0] radio_sig;
  logic [`N_CH-1:0] esc_sig;
  board_state_e     board_state;
  logic             motor_en;
  timestamp_t       timestamp;
  chan_vals_t       radio_vals;

  int           seed = 16662;
  int           errors;
  int           checks;
  int           cycles;
  int           run_start;
  int           test_err;
  int           drive_w [`N_CH];
  pulse_width_t model_vals [`N_CH];
  logic         exp_en;

  avionics_top UUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .shutdown_btn (shutdown_btn),
    .radio_sig    (radio_sig),
    .esc_sig      (esc_sig),
    .board_state  (board_state),
    .motor_en     (motor_en),
    .timestamp    (timestamp),
    .radio_vals   (radio_vals)
  );

  always #5 clk = ~clk;

  // Run length guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Simulation timed out after %0d clocks", cycles);
      $display("Errors found");
      $finish;
    end
  end

  function automatic int rand_range(input int lo, input int hi);
    int unsigned r;
    r = $unsigned($random(seed));
    return lo + int'(r % (hi - lo + 1));
  endfunction

  task automatic check_width(input pulse_width_t got, input pulse_width_t exp,
                             input int tol, input string what);
    int diff;
    diff = int'(got.width) - int'(exp.width);
    checks++;
    if (got.valid !== exp.valid || diff > tol || diff < -tol) begin
      errors++;
      $display("Error at %0d ns: %s width %0d valid %0b, expected %0d valid %0b",
               $time, what, got.width, got.valid, exp.width, exp.valid);
    end
  endtask

  task automatic check_state(input board_state_e got, input board_state_e exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s state %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s is %0b, expected %0b", $time, what, got, exp);
    end
  endtask

  task automatic check_stamp(input timestamp_t got, input int exp, input int tol);
    int diff;
    diff = int'(got) - exp;
    checks++;
    if (diff > tol || diff < -tol) begin
      errors++;
      $display("Error at %0d ns: timestamp %0d, expected %0d", $time, got, exp);
    end
  endtask

  // All channels start together, width 0 leaves a channel idle
  task automatic drive_pulses();
    int max_c;
    int lo_g;
    int hi_g;
    max_c = 0;
    lo_g  = `PULSE_MIN - `PULSE_GUARD;
    hi_g  = `PULSE_MAX + `PULSE_GUARD;
    for (int i = 0; i < `N_CH; i++) begin
      if (drive_w[i] * `US_DIV > max_c) max_c = drive_w[i] * `US_DIV;
    end
    @(negedge clk);
    for (int i = 0; i < `N_CH; i++) radio_sig[i] = (drive_w[i] != 0);
    for (int n = 1; n <= max_c; n++) begin
      @(negedge clk);
      for (int i = 0; i < `N_CH; i++) begin
        if (n == drive_w[i] * `US_DIV) radio_sig[i] = 1'b0;
      end
    end
    // Sync, edge and capture pipeline
    repeat (12) @(negedge clk);
    // Guard band accepted and clamped, anything else discarded
    for (int i = 0; i < `N_CH; i++) begin
      if (drive_w[i] != 0 && drive_w[i] >= lo_g && drive_w[i] <= hi_g) begin
        model_vals[i].valid = 1'b1;
        if (drive_w[i] < `PULSE_MIN) model_vals[i].width = `PULSE_MIN;
        else if (drive_w[i] > `PULSE_MAX) model_vals[i].width = `PULSE_MAX;
        else model_vals[i].width = drive_w[i];
      end
    end
  endtask

  task automatic compare_radio(input string what);
    for (int i = 0; i < `N_CH; i++) check_width(radio_vals[i], model_vals[i], 1, what);
  endtask

  // Arm needs ARM_HOLD ms after capture, plus slack
  task automatic wait_motor_en(input logic level);
    int n;
    n = 0;
    while (motor_en !== level && n < (`ARM_HOLD + 2) * MS_CLKS) begin
      @(negedge clk);
      n++;
    end
    if (motor_en !== level) begin
      errors++;
      $display("motor_en never reached %0b while waiting at %0d ns", level, $time);
    end
    exp_en = level;
  endtask

  // Stick low long enough to drop the flag, then high again for a fresh edge
  task automatic cycle_arm_stick(input logic level);
    for (int i = 0; i < `N_CH; i++) drive_w[i] = 0;
    drive_w[`ARM_CH] = 120;
    drive_pulses();
    repeat (2 * MS_CLKS) @(negedge clk);
    check_flag(motor_en, exp_en, "motor_en after stick low");
    drive_w[`ARM_CH] = 190;
    drive_pulses();
    wait_motor_en(level);
  endtask

  task automatic measure_esc();
    int           cnt [`N_CH];
    int           n;
    pulse_width_t got;
    pulse_width_t exp;
    n = 0;
    while (esc_sig == '0 && n < FRAME_CLKS) begin
      @(negedge clk);
      n++;
    end
    if (esc_sig !== '1) begin
      errors++;
      $display("ESC frame did not start with all outputs high at %0d ns", $time);
    end else begin
      for (int i = 0; i < `N_CH; i++) cnt[i] = 0;
      n = 0;
      while (esc_sig != '0 && n < FRAME_CLKS) begin
        for (int i = 0; i < `N_CH; i++) if (esc_sig[i]) cnt[i]++;
        @(negedge clk);
        n++;
      end
      for (int i = 0; i < `N_CH; i++) begin
        got.width = cnt[i] / `US_DIV;
        got.valid = 1'b1;
        exp.width = model_vals[i].valid ? model_vals[i].width : width_t'(`PULSE_MIN);
        exp.valid = 1'b1;
        check_width(got, exp, 1, "esc pulse");
      end
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("Test %0d %s finished, %0d mismatches", num, name, errors - test_err);
    test_err = errors;
  endtask

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    shutdown_btn = 1'b0;
    radio_sig    = '0;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    test_err     = 0;
    exp_en       = 1'b0;
    for (int i = 0; i < `N_CH; i++) model_vals[i] = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // 1: IDLE, STARTUP, RUNNING after reset
    check_state(board_state, IDLE, "after reset");
    @(negedge clk);
    check_state(board_state, STARTUP, "first clock");
    @(negedge clk);
    check_state(board_state, RUNNING, "second clock");
    run_start = cycles;
    check_flag(motor_en, 1'b0, "motor_en");
    check_flag(|esc_sig, 1'b0, "esc_sig");
    check_stamp(timestamp, 0, 1);
    end_test(1, "reset to running");

    // 2: legal, guard band, then discarded widths, arm stick kept low
    for (int i = 0; i < `N_CH; i++) begin
      drive_w[i] = (i == `ARM_CH) ? rand_range(`PULSE_MIN, 160)
                                  : rand_range(`PULSE_MIN, `PULSE_MAX);
    end
    drive_pulses();
    compare_radio("legal capture");
    for (int i = 0; i < `N_CH; i++) begin
      if (i == `ARM_CH || rand_range(0, 1) == 0) drive_w[i] = rand_range(82, 98);
      else drive_w[i] = rand_range(202, 218);
    end
    drive_pulses();
    compare_radio("guard band clamp");
    for (int i = 0; i < `N_CH; i++) begin
      drive_w[i] = rand_range(0, 1) ? rand_range(40, 77) : rand_range(223, 260);
    end
    drive_pulses();
    compare_radio("out of band hold");
    check_flag(motor_en, exp_en, "motor_en");
    end_test(2, "radio capture");

    // 3: arm, then one ESC frame
    for (int i = 0; i < `N_CH; i++) drive_w[i] = rand_range(`PULSE_MIN, `PULSE_MAX);
    drive_w[`ARM_CH] = 190;
    drive_pulses();
    compare_radio("arm capture");
    wait_motor_en(1'b1);
    measure_esc();
    end_test(3, "arming and esc frame");

    // 4: stick low then high again toggles motors off
    cycle_arm_stick(1'b0);
    @(negedge clk);
    for (int n = 0; n < FRAME_CLKS; n++) begin
      if (esc_sig != '0) begin
        errors++;
        $display("esc_sig went high at %0d ns with motors disabled", $time);
        break;
      end
      @(negedge clk);
    end
    end_test(4, "disarm");

    // 5: timestamp, rearm, then shutdown and restart
    repeat (rand_range(5, 8) * MS_CLKS) @(negedge clk);
    check_stamp(timestamp, (cycles - run_start) / MS_CLKS, 1);
    cycle_arm_stick(1'b1);
    shutdown_btn = 1'b1;
    begin : leave_running
      int n;
      n = 0;
      while (board_state == RUNNING && n < 8) begin
        @(negedge clk);
        n++;
      end
      if (n < 3 || n > 4) begin
        errors++;
        $display("Board left RUNNING %0d clocks after the button press", n);
      end
    end
    check_state(board_state, SHUTDOWN, "shutdown");
    check_flag(motor_en, 1'b0, "motor_en in shutdown");
    check_stamp(timestamp, 0, 0);
    for (int i = 0; i < `N_CH; i++) model_vals[i] = '0;
    exp_en = 1'b0;
    @(negedge clk);
    check_state(board_state, IDLE, "after shutdown");
    @(negedge clk);
    check_state(board_state, STARTUP, "restart");
    shutdown_btn = 1'b0;
    @(negedge clk);
    check_state(board_state, RUNNING, "restart");
    run_start = cycles;
    compare_radio("cleared capture");
    repeat (rand_range(3, 6) * MS_CLKS) @(negedge clk);
    check_stamp(timestamp, (cycles - run_start) / MS_CLKS, 1);
    check_flag(motor_en, exp_en, "motor_en after restart");
    end_test(5, "timestamp and shutdown");

    // 6: arm with some channels never captured, those run at PULSE_MIN
    for (int i = 0; i < `N_CH; i++) begin
      drive_w[i] = rand_range(0, 1) ? 0 : rand_range(`PULSE_MIN, `PULSE_MAX);
    end
    drive_w[(`ARM_CH + 1) % `N_CH] = 0;
    drive_w[`ARM_CH] = 190;
    drive_pulses();
    compare_radio("partial capture");
    wait_motor_en(1'b1);
    measure_esc();
    end_test(6, "esc with invalid channels");

    $display("Checks run: %0d, mismatches: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+src
src/avionics_pkg.sv
src/tick_gen.sv
src/pulse_capture.sv
src/arm_switch.sv
src/esc_pwm.sv
src/board_ctrl.sv
src/avionics_top.sv
tests/tb_avionics.sv
